// File: Bender.yml
package:
  name: mister_frame

sources:
  - include_dirs:
      - .
    files:
      - mister_frame_pkg.sv
      - dwnld_ctrl.sv
      - cfg_regs.sv
      - sync_resync.sv
      - mister_frame.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mister_frame.sv

// File: cfg_regs.sv
// DIP, cheat and offset registers
`timescale 1ns/100ps
`default_nettype none

`include "mister_frame_settings.svh"

module cfg_regs (
    input  logic                           clk_rom,
    input  logic                           rst,
    input  mister_frame_pkg::ioctl_t       ioctl,
    input  mister_frame_pkg::dwnld_kind_e  kind,
    input  logic                           cfg_we,
    input  logic [31:0]                    status,
    output logic [31:0]                    dipsw,
    output logic [31:0]                    cheat,
    output mister_frame_pkg::sync_offset_t offsets
);
    import mister_frame_pkg::*;

    logic [31:0] dip_q;
    logic [31:0] cheat_q;
    logic        dip_we;
    logic        cheat_we;

    // Little endian, byte lane taken from the address
    function automatic logic [31:0] put_byte(
        input logic [31:0] word,
        input logic [1:0]  lane,
        input logic [7:0]  data
    );
        logic [31:0] res;
        res = word;
        res[lane*8 +: 8] = data;
        return res;
    endfunction

    assign dip_we   = cfg_we && kind == DIP;
    assign cheat_we = cfg_we && kind == CHEAT;

    // New byte shows on the word in the same cycle as the write strobe
    assign dipsw = dip_we ? put_byte(dip_q, ioctl.addr[1:0], ioctl.dout) : dip_q;
    assign cheat = cheat_we ? put_byte(cheat_q, ioctl.addr[1:0], ioctl.dout) : cheat_q;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            dip_q   <= 32'd0;
            cheat_q <= 32'd0;
        end else begin
            dip_q   <= dipsw;
            cheat_q <= cheat;
        end
    end

    // Sync offsets from the OSD
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            offsets <= '0;
        end else begin
            offsets <= sync_offset_t'(status[`MF_OFFSET_LSB +: 8]);
        end
    end

endmodule

`default_nettype wire

// File: dwnld_ctrl.sv
// Download control FSM
`timescale 1ns/100ps
`default_nettype none

`include "mister_frame_settings.svh"

module dwnld_ctrl (
    input  logic                          clk_rom,
    input  logic                          rst,
    input  mister_frame_pkg::hps_xfer_t   hps,
    input  logic                          prog_rdy,
    input  logic                          dwnld_busy,
    output logic                          hps_wait,
    output logic                          downloading,
    output logic                          ioctl_rom_wr,
    output logic                          ioctl_ram,
    output logic                          ioctl_cheat,
    output mister_frame_pkg::ioctl_t      ioctl,
    output mister_frame_pkg::dwnld_kind_e kind,
    output logic                          cfg_we
);
    import mister_frame_pkg::*;

    dwnld_state_e state;
    dwnld_state_e state_nxt;
    dwnld_kind_e  kind_dec;
    logic         kind_ld;
    logic         wr_ok;

    // Index decode, unknown indices are ignored
    always_comb begin
        case (hps.index)
            `MF_IDX_ROM:   kind_dec = ROM;
            `MF_IDX_CHEAT: kind_dec = CHEAT;
            `MF_IDX_DIP:   kind_dec = DIP;
            `MF_IDX_NVRAM: kind_dec = NVRAM;
            default:       kind_dec = NONE;
        endcase
    end

    // A new download may also start during the busy tail
    assign kind_ld = hps.download && (state == IDLE || state == TAIL);

    // Bytes are only taken while active, never during the ROM wait
    assign wr_ok = hps.wr && hps.download && state == ACTIVE && kind != NONE;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (hps.download) begin
                    state_nxt = ACTIVE;
                end
            end
            ACTIVE: begin
                if (wr_ok && kind == ROM) begin
                    state_nxt = ROM_WAIT;
                end else if (!hps.download) begin
                    state_nxt = dwnld_busy ? TAIL : IDLE;
                end
            end
            ROM_WAIT: begin
                if (prog_rdy) begin
                    state_nxt = ACTIVE;
                end
            end
            TAIL: begin
                if (hps.download) begin
                    state_nxt = ACTIVE;
                end else if (!dwnld_busy) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            state        <= IDLE;
            kind         <= NONE;
            ioctl_rom_wr <= 1'b0;
            cfg_we       <= 1'b0;
        end else begin
            state        <= state_nxt;
            ioctl_rom_wr <= wr_ok && kind == ROM;
            cfg_we       <= wr_ok && (kind == DIP || kind == CHEAT);
            if (kind_ld) begin
                kind <= kind_dec;
            end
        end
    end

    // Address also serves NVRAM transfers
    always_ff @(posedge clk_rom) begin
        if (wr_ok) begin
            ioctl.addr <= hps.addr;
            ioctl.dout <= hps.dout;
        end
    end

    assign hps_wait    = state == ROM_WAIT;
    assign downloading = state != IDLE;
    assign ioctl_ram   = downloading && kind == NVRAM;
    assign ioctl_cheat = downloading && kind == CHEAT;

    // HPS side must hold its strobe while a ROM byte is pending
    assert property (@(posedge clk_rom) disable iff (rst) hps_wait |-> !hps.wr)
        else $error("hps.wr seen while hps_wait is high, byte dropped");

    // Each ROM byte reaches the SDRAM loader as a single pulse
    assert property (@(posedge clk_rom) disable iff (rst) ioctl_rom_wr |=> !ioctl_rom_wr)
        else $error("ioctl_rom_wr high on two consecutive cycles");

endmodule

`default_nettype wire

// File: mister_frame.sv
// MiSTer frame download and sync top
`timescale 1ns/100ps
`default_nettype none

module mister_frame (
    input  logic                           clk_rom,
    input  logic                           rst,
    // HPS download
    input  mister_frame_pkg::hps_xfer_t    hps,
    output logic                           hps_wait,
    // ROM, NVRAM and cheat programming
    output mister_frame_pkg::ioctl_t       ioctl,
    output logic                           ioctl_rom_wr,
    output logic                           ioctl_ram,
    output logic                           ioctl_cheat,
    input  logic                           prog_rdy,
    input  logic                           dwnld_busy,
    output logic                           downloading,
    // Configuration words
    input  logic [31:0]                    status,
    output logic [31:0]                    dipsw,
    output logic [31:0]                    cheat,
    // Video timing
    input  logic                           pxl_cen,
    input  logic                           LHBL,
    input  logic                           LVBL,
    input  mister_frame_pkg::sync_t        sync_in,
    output mister_frame_pkg::sync_t        sync_out
);
    import mister_frame_pkg::*;

    dwnld_kind_e  kind;
    logic         cfg_we;
    sync_offset_t offsets;

    dwnld_ctrl u_dwnld (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .hps            ( hps            ),
        .prog_rdy       ( prog_rdy       ),
        .dwnld_busy     ( dwnld_busy     ),
        .hps_wait       ( hps_wait       ),
        .downloading    ( downloading    ),
        .ioctl_rom_wr   ( ioctl_rom_wr   ),
        .ioctl_ram      ( ioctl_ram      ),
        .ioctl_cheat    ( ioctl_cheat    ),
        .ioctl          ( ioctl          ),
        .kind           ( kind           ),
        .cfg_we         ( cfg_we         )
    );

    cfg_regs u_cfg (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .ioctl          ( ioctl          ),
        .kind           ( kind           ),
        .cfg_we         ( cfg_we         ),
        .status         ( status         ),
        .dipsw          ( dipsw          ),
        .cheat          ( cheat          ),
        .offsets        ( offsets        )
    );

    // Runs on the download clock as well
    sync_resync u_resync (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .pxl_cen        ( pxl_cen        ),
        .LHBL           ( LHBL           ),
        .LVBL           ( LVBL           ),
        .sync_in        ( sync_in        ),
        .offsets        ( offsets        ),
        .sync_out       ( sync_out       )
    );

endmodule

`default_nettype wire

// File: mister_frame_pkg.sv
// Frame wrapper types
`default_nettype none

`include "mister_frame_settings.svh"

package mister_frame_pkg;

    // Download kind, picked from the HPS index
    typedef enum logic [2:0] {
        ROM,
        CHEAT,
        DIP,
        NVRAM,
        NONE
    } dwnld_kind_e;

    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        ROM_WAIT,
        TAIL
    } dwnld_state_e;

    // One HPS download beat
    typedef struct packed {
        logic                    download;
        logic                    wr;
        logic [`MF_IDXW-1:0]     index;
        logic [`MF_ADDRW-1:0]    addr;
        logic [7:0]              dout;
    } hps_xfer_t;

    // Byte as it leaves the controller
    typedef struct packed {
        logic [`MF_ADDRW-1:0]    addr;
        logic [7:0]              dout;
    } ioctl_t;

    typedef struct packed {
        logic hs;
        logic vs;
    } sync_t;

    // Same bit order as status[31:24]
    typedef struct packed {
        logic [3:0] voffset;
        logic [3:0] hoffset;
    } sync_offset_t;

endpackage

`default_nettype wire

// File: mister_frame_settings.svh
// Frame wrapper settings
`ifndef MISTER_FRAME_SETTINGS_SVH
`define MISTER_FRAME_SETTINGS_SVH

// Download indices sent by the HPS with each transfer
`define MF_IDX_ROM      8'd0
`define MF_IDX_CHEAT    8'd16
`define MF_IDX_DIP      8'd254
`define MF_IDX_NVRAM    8'd255

// Download bus widths
`define MF_ADDRW        27
`define MF_IDXW         8

// First status bit of the sync offsets, hoffset below voffset
`define MF_OFFSET_LSB   24

`endif

// File: mister_frame_tests.txt
# name kind index(hex) count addr(hex) data(hex, byte i to addr+i) delay offsets(hex) expected(hex)
# delay is prog_rdy wait for rom (-1 random), busy tail for nvram; offsets are status[31:24]
rom_basic     rom   00 4 0000000 44332211  2 00 00000000
rom_no_wait   rom   00 4 0000100 a5a55a5a  0 00 00000000
rom_random    rom   00 4 1fffffc 0badf00d -1 00 00000000
rom_single    rom   00 1 0000010 000000ee  5 00 00000000
dip_full      dip   fe 4 0000000 12345678  0 00 12345678
dip_upper     dip   fe 2 0000002 0000abcd  0 00 abcd5678
dip_lane1     dip   fe 1 0000001 000000ee  0 00 abcdee78
cheat_full    cheat 10 4 0000000 cafef00d  0 00 cafef00d
cheat_lane0   cheat 10 1 0000000 00000011  0 00 cafef011
nvram_busy    nvram ff 2 0000040 0000beef  6 00 00000000
nvram_plain   nvram ff 3 0000080 00c0ffee  0 00 00000000
unknown_index none  07 2 0000000 00005555  0 00 00000000
sync_h0_v0    sync  00 0 0000000 00000000  0 00 00000000
sync_h2_v1    sync  00 0 0000000 00000000  0 12 00000000
sync_h3_v0    sync  00 0 0000000 00000000  0 03 00000000
sync_h1_v1    sync  00 0 0000000 00000000  0 11 00000000

// File: sync_resync.sv
// Video sync resynchronizer
`timescale 1ns/100ps
`default_nettype none

module sync_resync (
    input  logic                           clk_rom,
    input  logic                           rst,
    input  logic                           pxl_cen,
    input  logic                           LHBL,
    input  logic                           LVBL,
    input  mister_frame_pkg::sync_t        sync_in,
    input  mister_frame_pkg::sync_offset_t offsets,
    output mister_frame_pkg::sync_t        sync_out
);
    import mister_frame_pkg::*;

    sync_t       sync_l;
    sync_t       sync_ll;
    logic        cen_l;
    logic        lhbl_l;
    logic        lvbl_l;
    // Index 0 is the rising edge, 1 the falling edge
    logic  [1:0] hs_edge;
    logic  [1:0] vs_edge;
    logic  [1:0] hs_fire;
    logic  [1:0] vs_fire;
    logic  [1:0] hpend;
    logic  [1:0] vpend;
    logic  [3:0] hcnt [2];
    logic  [3:0] vcnt [2];
    logic  [7:0] w_in;
    logic  [7:0] w_out;
    logic        out_hs_l;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            sync_l  <= '0;
            sync_ll <= '0;
            cen_l   <= 1'b0;
            lhbl_l  <= 1'b1;
            lvbl_l  <= 1'b1;
        end else begin
            sync_l  <= sync_in;
            sync_ll <= sync_l;
            cen_l   <= pxl_cen;
            lhbl_l  <= LHBL;
            lvbl_l  <= LVBL;
        end
    end

    // Edges only count inside blanking
    assign hs_edge[0] = sync_l.hs & ~sync_ll.hs & ~lhbl_l;
    assign hs_edge[1] = ~sync_l.hs & sync_ll.hs & ~lhbl_l;
    assign vs_edge[0] = sync_l.vs & ~sync_ll.vs & ~lvbl_l;
    assign vs_edge[1] = ~sync_l.vs & sync_ll.vs & ~lvbl_l;

    always_comb begin
        for (int e = 0; e < 2; e++) begin
            hs_fire[e] = (hs_edge[e] && offsets.hoffset == 4'd0)
                      || (hpend[e] && cen_l && hcnt[e] == 4'd1);
            // vs moves only on delayed hs rising edges
            vs_fire[e] = hs_fire[0] && ((vs_edge[e] && offsets.voffset == 4'd0)
                                     || (vpend[e] && vcnt[e] == 4'd0));
        end
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            hpend <= 2'b00;
            vpend <= 2'b00;
            for (int e = 0; e < 2; e++) begin
                hcnt[e] <= 4'd0;
                vcnt[e] <= 4'd0;
            end
        end else begin
            for (int e = 0; e < 2; e++) begin
                // Pixel enables left before the hs edge goes out
                if (hs_edge[e]) begin
                    hpend[e] <= offsets.hoffset != 4'd0;
                    hcnt[e]  <= offsets.hoffset;
                end else if (hpend[e] && cen_l) begin
                    hpend[e] <= hcnt[e] != 4'd1;
                    hcnt[e]  <= hcnt[e] - 4'd1;
                end
                // Lines left before the vs edge goes out, a coincident hs edge is line zero
                if (vs_edge[e]) begin
                    vpend[e] <= !vs_fire[e];
                    vcnt[e]  <= (hs_fire[0] && offsets.voffset != 4'd0) ?
                                offsets.voffset - 4'd1 : offsets.voffset;
                end else if (vpend[e] && hs_fire[0]) begin
                    vpend[e] <= vcnt[e] != 4'd0;
                    vcnt[e]  <= vcnt[e] - 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            sync_out <= '0;
            out_hs_l <= 1'b0;
        end else begin
            if (hs_fire[0]) begin
                sync_out.hs <= 1'b1;
            end else if (hs_fire[1]) begin
                sync_out.hs <= 1'b0;
            end
            if (vs_fire[0]) begin
                sync_out.vs <= 1'b1;
            end else if (vs_fire[1]) begin
                sync_out.vs <= 1'b0;
            end
            out_hs_l <= sync_out.hs;
        end
    end

    // Pulse widths in pixel enables, source and delayed
    always_ff @(posedge clk_rom) begin
        if (hs_edge[0]) begin
            w_in <= {7'd0, pxl_cen};
        end else if (sync_l.hs) begin
            w_in <= w_in + {7'd0, pxl_cen};
        end
        if (hs_fire[0]) begin
            w_out <= 8'd0;
        end else if (sync_out.hs) begin
            w_out <= w_out + {7'd0, cen_l};
        end
    end

    assert property (@(posedge clk_rom) disable iff (rst)
        (out_hs_l && !sync_out.hs) |-> (w_out == w_in))
        else $error("delayed hs width %0d differs from source width %0d", w_out, w_in);

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_mister_frame.sv
// Frame wrapper testbench
`timescale 1ns/100ps
`default_nettype none

module tb_mister_frame;
    import mister_frame_pkg::*;

    localparam int SYNC_CYCLES = 144;
    localparam int LINE_LEN    = 24;

    logic        clk;
    logic        rst;
    hps_xfer_t   hps;
    logic        hps_wait;
    ioctl_t      ioctl;
    logic        ioctl_rom_wr;
    logic        ioctl_ram;
    logic        ioctl_cheat;
    logic        prog_rdy;
    logic        dwnld_busy;
    logic        downloading;
    logic [31:0] status;
    logic [31:0] dipsw;
    logic [31:0] cheat;
    logic        pxl_cen;
    logic        LHBL;
    logic        LVBL;
    sync_t       sync_in;
    sync_t       sync_out;

    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          rom_pulses = 0;
    logic [31:0] dip_ref = 32'd0;
    logic [31:0] cheat_ref = 32'd0;
    string       tests[$];

    tb_clk_gen u_clk (
        .clk ( clk ),
        .rst ( rst )
    );

    mister_frame i_mister_frame (
        .clk_rom      ( clk          ),
        .rst          ( rst          ),
        .hps          ( hps          ),
        .hps_wait     ( hps_wait     ),
        .ioctl        ( ioctl        ),
        .ioctl_rom_wr ( ioctl_rom_wr ),
        .ioctl_ram    ( ioctl_ram    ),
        .ioctl_cheat  ( ioctl_cheat  ),
        .prog_rdy     ( prog_rdy     ),
        .dwnld_busy   ( dwnld_busy   ),
        .downloading  ( downloading  ),
        .status       ( status       ),
        .dipsw        ( dipsw        ),
        .cheat        ( cheat        ),
        .pxl_cen      ( pxl_cen      ),
        .LHBL         ( LHBL         ),
        .LVBL         ( LVBL         ),
        .sync_in      ( sync_in      ),
        .sync_out     ( sync_out     )
    );

    // Run limit and ROM pulse count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (!rst && ioctl_rom_wr) begin
            rom_pulses = rom_pulses + 1;
        end
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            failures = failures + 1;
            $display("Run stopped after %0d cycles, the tests did not finish", cycles);
            $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic log_mismatch(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        mismatches = mismatches + 1;
        $display("MISMATCH %s: %s expected %h actual %h", name, what, exp, act);
    endtask

    task automatic log_failure(input string name, input string msg);
        failures = failures + 1;
        $display("Test %s: %s", name, msg);
    endtask

    task automatic run_download(input string name, input string kind,
                                input logic [7:0] index, input int count,
                                input logic [26:0] addr, input logic [31:0] data,
                                input int delay, input logic [31:0] expv);
        int          pulses0;
        int          wait_cycles;
        int          busy_len;
        logic [26:0] a;
        logic [7:0]  d;
        pulses0  = rom_pulses;
        busy_len = (kind == "nvram") ? delay : 0;
        hps.download = 1'b1;
        hps.index    = index;
        step();
        if (!downloading) log_failure(name, "downloading did not rise after download start");
        if (kind == "cheat" && !ioctl_cheat) log_failure(name, "ioctl_cheat low during download");
        if (kind == "nvram" && !ioctl_ram) log_failure(name, "ioctl_ram low during download");
        for (int i = 0; i < count; i++) begin
            a = addr + i;
            d = data[8*i +: 8];
            hps.wr   = 1'b1;
            hps.addr = a;
            hps.dout = d;
            step();
            hps.wr = 1'b0;
            if (kind == "rom") begin
                if (!ioctl_rom_wr) log_failure(name, "no ioctl_rom_wr pulse after hps.wr");
                if (ioctl.addr != a) log_mismatch(name, "ioctl.addr", a, ioctl.addr);
                if (ioctl.dout != d) log_mismatch(name, "ioctl.dout", d, ioctl.dout);
                if (!hps_wait) log_failure(name, "hps_wait not raised for ROM byte");
                wait_cycles = (delay < 0) ? $urandom % 8 : delay;
                repeat (wait_cycles) begin
                    step();
                    if (!hps_wait) log_failure(name, "hps_wait fell before prog_rdy");
                end
                prog_rdy = 1'b1;
                step();
                prog_rdy = 1'b0;
                if (hps_wait) log_failure(name, "hps_wait still high one cycle after prog_rdy");
            end else if (hps_wait) begin
                log_failure(name, "hps_wait raised for a byte that is not ROM");
            end
        end
        hps.download = 1'b0;
        dwnld_busy   = busy_len > 0;
        step();
        for (int j = 0; j < busy_len; j++) begin
            if (!downloading) log_failure(name, "downloading fell while dwnld_busy was high");
            if (!ioctl_ram) log_failure(name, "ioctl_ram fell while dwnld_busy was high");
            if (j == busy_len - 1) dwnld_busy = 1'b0;
            step();
        end
        if (downloading) log_failure(name, "downloading still high after the download ended");
        if (ioctl_ram || ioctl_cheat) log_failure(name, "kind level still high after download");
        if (kind == "dip") dip_ref = expv;
        if (kind == "cheat") cheat_ref = expv;
        if (dipsw != dip_ref) log_mismatch(name, "dipsw", dip_ref, dipsw);
        if (cheat != cheat_ref) log_mismatch(name, "cheat", cheat_ref, cheat);
        if (kind == "rom" && rom_pulses - pulses0 != count) begin
            log_mismatch(name, "ioctl_rom_wr pulses", count, rom_pulses - pulses0);
        end
        if (kind != "rom" && rom_pulses != pulses0) log_failure(name, "unexpected ROM pulse");
    endtask

    task automatic run_sync(input string name, input logic [7:0] offs);
        logic in_hs  [SYNC_CYCLES];
        logic in_vs  [SYNC_CYCLES];
        logic cen    [SYNC_CYCLES];
        logic obs_hs [SYNC_CYCLES];
        logic obs_vs [SYNC_CYCLES];
        logic exp_hs [SYNC_CYCLES];
        logic exp_vs [SYNC_CYCLES];
        logic hs_rise[SYNC_CYCLES];
        logic prev;
        int   hoff;
        int   voff;
        int   t;
        int   n;
        int   first_hs;
        int   first_vs;
        hoff = offs[3:0];
        voff = offs[7:4];
        status[31:24] = offs;
        repeat (3) step();
        for (int k = 0; k < SYNC_CYCLES; k++) begin
            obs_hs[k] = sync_out.hs;
            obs_vs[k] = sync_out.vs;
            in_hs[k]  = (k % LINE_LEN) >= 4 && (k % LINE_LEN) < 10;
            in_vs[k]  = k >= 30 && k < 78;
            cen[k]    = (k % 2) == 1;
            sync_in.hs = in_hs[k];
            sync_in.vs = in_vs[k];
            pxl_cen    = cen[k];
            step();
        end
        sync_in = '0;
        pxl_cen = 1'b0;
        for (int k = 0; k < SYNC_CYCLES; k++) begin
            exp_hs[k]  = 1'b0;
            exp_vs[k]  = 1'b0;
            hs_rise[k] = 1'b0;
        end
        // Each hs edge moves by hoffset pixel enables plus two cycles
        for (int k = 0; k < SYNC_CYCLES; k++) begin
            prev = (k == 0) ? 1'b0 : in_hs[k-1];
            if (in_hs[k] != prev) begin
                t = (hoff == 0) ? k + 2 : -1;
                n = 0;
                for (int j = k + 1; j < SYNC_CYCLES && t < 0; j++) begin
                    if (cen[j]) n++;
                    if (cen[j] && n == hoff) t = j + 2;
                end
                for (int j = t; j >= 0 && j < SYNC_CYCLES; j++) exp_hs[j] = in_hs[k];
                if (in_hs[k] && t >= 0 && t < SYNC_CYCLES) hs_rise[t] = 1'b1;
            end
        end
        // Each vs edge lands on the voffset-th delayed hs rise at or after it
        for (int k = 0; k < SYNC_CYCLES; k++) begin
            prev = (k == 0) ? 1'b0 : in_vs[k-1];
            if (in_vs[k] != prev) begin
                t = -1;
                n = 0;
                for (int j = k + 2; j < SYNC_CYCLES && t < 0; j++) begin
                    if (hs_rise[j] && n == voff) t = j;
                    if (hs_rise[j]) n++;
                end
                for (int j = t; j >= 0 && j < SYNC_CYCLES; j++) exp_vs[j] = in_vs[k];
            end
        end
        first_hs = 1;
        first_vs = 1;
        for (int k = 0; k < SYNC_CYCLES; k++) begin
            if (obs_hs[k] !== exp_hs[k]) begin
                if (first_hs) log_mismatch(name, $sformatf("sync_out.hs at cycle %0d", k),
                                           exp_hs[k], obs_hs[k]);
                else mismatches = mismatches + 1;
                first_hs = 0;
            end
            if (obs_vs[k] !== exp_vs[k]) begin
                if (first_vs) log_mismatch(name, $sformatf("sync_out.vs at cycle %0d", k),
                                           exp_vs[k], obs_vs[k]);
                else mismatches = mismatches + 1;
                first_vs = 0;
            end
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          count;
        int          delay;
        string       line;
        string       name;
        string       kind;
        logic [7:0]  index;
        logic [26:0] addr;
        logic [31:0] data;
        logic [7:0]  offs;
        logic [31:0] expv;
        hps        = '0;
        prog_rdy   = 1'b0;
        dwnld_busy = 1'b0;
        status     = 32'd0;
        pxl_cen    = 1'b0;
        LHBL       = 1'b0;
        LVBL       = 1'b0;
        sync_in    = '0;
        void'($urandom(81016));
        fd = $fopen("mister_frame_tests.txt", "r");
        if (fd == 0) begin
            failures = failures + 1;
            $display("Cannot open mister_frame_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) && line.len() > 1 && line.substr(0, 0) != "#") begin
                    tests.push_back(line);
                end
            end
            $fclose(fd);
            cycle_limit = 64 * tests.size() + 200;
            step();
            while (rst) step();
            foreach (tests[i]) begin
                fields = $sscanf(tests[i], "%s %s %h %d %h %h %d %h %h", name, kind,
                                 index, count, addr, data, delay, offs, expv);
                if (fields != 9) begin
                    log_failure($sformatf("line %0d", i), "malformed test line");
                end else if (kind == "sync") begin
                    run_sync(name, offs);
                end else begin
                    status[31:24] = offs;
                    run_download(name, kind, index, count, addr, data, delay, expv);
                end
            end
        end
        $display("Tests: %0d, mismatches: %0d, other errors: %0d",
                 tests.size(), mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mister_frame_pkg.sv
dwnld_ctrl.sv
cfg_regs.sv
sync_resync.sv
mister_frame.sv
tb_clk_gen.sv
tb_mister_frame.sv
